//--- common/fib_pkg.sv
package fib_pkg;

    // Byte lane used on both SPI directions and toward the PIT
    parameter int BYTE_W = 8;

    // Name prefix carried in every header
    parameter int PREFIX_W = 64;

    // Leading metadata byte
    parameter int META_W = 8;

    // Header is one metadata byte plus the prefix
    parameter int HDR_BYTES = 9;
    parameter int HDR_W = META_W + PREFIX_W;

    // Wide enough to count 0..HDR_BYTES
    parameter int HDR_CNT_W = $clog2(HDR_BYTES + 1);

    // Metadata bit 6 set marks an interest, clear marks a data packet
    parameter int META_INTEREST_BIT = 6;

    // Route table addressing, sized for the default eight entries
    parameter int ROUTE_IDX_W = 3;

endpackage

//--- logic/rx_deframer.sv
module rx_deframer #(
    parameter int PAYLOAD_BYTES = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rx_valid,
    input  logic [fib_pkg::BYTE_W-1:0]   data_spi_to_fib,
    input  logic                         rejected,
    output logic [fib_pkg::PREFIX_W-1:0] pit_out_prefix,
    output logic [fib_pkg::META_W-1:0]   pit_out_metadata,
    output logic                         prefix_ready,
    output logic [fib_pkg::BYTE_W-1:0]   data_fib_to_pit,
    output logic                         pit_data_valid
);

    localparam int HCW = fib_pkg::HDR_CNT_W;
    localparam int PCW = $clog2(PAYLOAD_BYTES + 1);

    logic [HCW-1:0]               hdr_cnt;
    logic [PCW-1:0]               pay_cnt;
    logic                         in_payload;
    logic                         frame_interest;
    logic                         drop_q;
    logic [fib_pkg::HDR_W-1:0]    hdr_sr;
    logic                         last_hdr_byte;
    logic                         last_pay_byte;
    logic                         drop_now;

    assign last_hdr_byte = rx_valid && !in_payload &&
                           (hdr_cnt == HCW'(fib_pkg::HDR_BYTES - 1));
    assign last_pay_byte = rx_valid && in_payload &&
                           (pay_cnt == PCW'(PAYLOAD_BYTES - 1));

    // First payload byte may land in the prefix_ready cycle itself,
    // so the PIT verdict is used directly there and latched afterwards
    assign drop_now = prefix_ready ? rejected : drop_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_cnt        <= '0;
            pay_cnt        <= '0;
            in_payload     <= 1'b0;
            frame_interest <= 1'b0;
            drop_q         <= 1'b0;
            prefix_ready   <= 1'b0;
            pit_data_valid <= 1'b0;
        end else begin
            prefix_ready   <= last_hdr_byte;
            pit_data_valid <= rx_valid && in_payload && !drop_now;

            if (prefix_ready) begin
                drop_q <= rejected;
            end

            if (rx_valid) begin
                if (in_payload) begin
                    if (last_pay_byte) begin
                        in_payload <= 1'b0;
                        pay_cnt    <= '0;
                    end else begin
                        pay_cnt <= pay_cnt + 1'b1;
                    end
                end else if (last_hdr_byte) begin
                    // Interest frames stop at the header
                    hdr_cnt    <= '0;
                    in_payload <= !frame_interest;
                end else begin
                    if (hdr_cnt == '0) begin
                        frame_interest <= data_spi_to_fib[fib_pkg::META_INTEREST_BIT];
                    end
                    hdr_cnt <= hdr_cnt + 1'b1;
                end
            end
        end
    end

    // Header shifts in MSB first; it holds still during the payload
    always_ff @(posedge clk) begin
        if (rx_valid && !in_payload) begin
            hdr_sr <= {hdr_sr[fib_pkg::HDR_W-fib_pkg::BYTE_W-1:0], data_spi_to_fib};
        end
        if (rx_valid && in_payload) begin
            data_fib_to_pit <= data_spi_to_fib;
        end
    end

    assign pit_out_metadata = hdr_sr[fib_pkg::HDR_W-1 -: fib_pkg::META_W];
    assign pit_out_prefix   = hdr_sr[fib_pkg::PREFIX_W-1:0];

    a_prefix_ready_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        prefix_ready |=> !prefix_ready
    ) else $error("prefix_ready held longer than one cycle");

endmodule

//--- logic/tx_serializer.sv
module tx_serializer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load,
    input  logic [fib_pkg::PREFIX_W-1:0] load_prefix,
    input  logic [fib_pkg::META_W-1:0]   load_metadata,
    output logic [fib_pkg::BYTE_W-1:0]   data_fib_to_spi,
    output logic                         fib_to_spi_data_flag,
    output logic                         tx_done
);

    localparam int CW = fib_pkg::HDR_CNT_W;

    logic [fib_pkg::HDR_W-1:0] shift_sr;
    logic [CW-1:0]             byte_cnt;

    // Counts the bytes still to go, including the one on the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
        end else if (load) begin
            byte_cnt <= CW'(fib_pkg::HDR_BYTES);
        end else if (byte_cnt != '0) begin
            byte_cnt <= byte_cnt - 1'b1;
        end
    end

    // Metadata goes out first, then the prefix MSB first
    always_ff @(posedge clk) begin
        if (load) begin
            shift_sr <= {load_metadata, load_prefix};
        end else if (fib_to_spi_data_flag) begin
            shift_sr <= shift_sr << fib_pkg::BYTE_W;
        end
    end

    assign fib_to_spi_data_flag = (byte_cnt != '0);
    assign data_fib_to_spi      = shift_sr[fib_pkg::HDR_W-1 -: fib_pkg::BYTE_W];

    // High together with the final header byte
    assign tx_done = (byte_cnt == CW'(1));

    a_no_load_while_shifting: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |-> !fib_to_spi_data_flag
    ) else $error("load arrived while a header was still being sent");

endmodule

//--- fib/fib_lookup.sv
module fib_lookup #(
    parameter int ROUTES = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            route_we,
    input  logic [fib_pkg::ROUTE_IDX_W-1:0] route_index,
    input  logic [fib_pkg::PREFIX_W-1:0]    route_prefix,
    input  logic [fib_pkg::PREFIX_W-1:0]    route_mask,
    input  logic                            fib_out_bit,
    input  logic [fib_pkg::PREFIX_W-1:0]    pit_in_prefix,
    input  logic [fib_pkg::META_W-1:0]      pit_in_metadata,
    input  logic                            tx_done,
    output logic                            load,
    output logic [fib_pkg::PREFIX_W-1:0]    load_prefix,
    output logic [fib_pkg::META_W-1:0]      load_metadata,
    output logic                            fib_miss,
    output logic                            fib_busy
);

    logic [fib_pkg::PREFIX_W-1:0] tbl_prefix [ROUTES];
    logic [fib_pkg::PREFIX_W-1:0] tbl_mask   [ROUTES];
    logic [ROUTES-1:0]            tbl_valid;
    logic [ROUTES-1:0]            match_vec;
    logic                         hit;

    if (ROUTES > (1 << fib_pkg::ROUTE_IDX_W)) begin : g_routes_check
        $error("ROUTES exceeds the range of route_index");
    end

    // Valid bits are the only table state that needs clearing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tbl_valid <= '0;
        end else if (route_we) begin
            tbl_valid[route_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (route_we) begin
            tbl_prefix[route_index] <= route_prefix;
            tbl_mask[route_index]   <= route_mask;
        end
    end

    // Masked compare against every entry in parallel
    always_comb begin
        for (int i = 0; i < ROUTES; i++) begin
            match_vec[i] = tbl_valid[i] &&
                ((pit_in_prefix & tbl_mask[i]) == (tbl_prefix[i] & tbl_mask[i]));
        end
    end

    // Lowest matching index wins, but every entry leads to the same SPI port,
    // so only the presence of a winner matters here
    assign hit = |match_vec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load     <= 1'b0;
            fib_miss <= 1'b0;
            fib_busy <= 1'b0;
        end else begin
            load     <= fib_out_bit && hit;
            fib_miss <= fib_out_bit && !hit;

            // Busy spans the lookup cycle and, on a hit, the whole transmit
            if (fib_out_bit) begin
                fib_busy <= 1'b1;
            end else if (fib_miss || tx_done) begin
                fib_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fib_out_bit) begin
            load_prefix   <= pit_in_prefix;
            load_metadata <= pit_in_metadata;
        end
    end

    a_no_request_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        fib_out_bit |-> !fib_busy
    ) else $error("PIT requested a lookup while fib_busy was high");

endmodule

//--- fib/fib_top.sv
module fib_top #(
    parameter int ROUTES        = 8,
    parameter int PAYLOAD_BYTES = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // SPI to FIB
    input  logic                            rx_valid,
    input  logic [fib_pkg::BYTE_W-1:0]      data_spi_to_fib,

    // FIB to PIT, inbound headers and payload
    input  logic                            rejected,
    output logic [fib_pkg::PREFIX_W-1:0]    pit_out_prefix,
    output logic [fib_pkg::META_W-1:0]      pit_out_metadata,
    output logic                            prefix_ready,
    output logic [fib_pkg::BYTE_W-1:0]      data_fib_to_pit,
    output logic                            pit_data_valid,

    // Route table programming
    input  logic                            route_we,
    input  logic [fib_pkg::ROUTE_IDX_W-1:0] route_index,
    input  logic [fib_pkg::PREFIX_W-1:0]    route_prefix,
    input  logic [fib_pkg::PREFIX_W-1:0]    route_mask,

    // PIT to FIB, outgoing interests
    input  logic                            fib_out_bit,
    input  logic [fib_pkg::PREFIX_W-1:0]    pit_in_prefix,
    input  logic [fib_pkg::META_W-1:0]      pit_in_metadata,
    output logic                            fib_miss,
    output logic                            fib_busy,

    // FIB to SPI
    output logic [fib_pkg::BYTE_W-1:0]      data_fib_to_spi,
    output logic                            fib_to_spi_data_flag
);

    logic                         load;
    logic [fib_pkg::PREFIX_W-1:0] load_prefix;
    logic [fib_pkg::META_W-1:0]   load_metadata;
    logic                         tx_done;

    rx_deframer #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES)
    ) u_rx_deframer (
        .clk              (clk),
        .rst_n            (rst_n),
        .rx_valid         (rx_valid),
        .data_spi_to_fib  (data_spi_to_fib),
        .rejected         (rejected),
        .pit_out_prefix   (pit_out_prefix),
        .pit_out_metadata (pit_out_metadata),
        .prefix_ready     (prefix_ready),
        .data_fib_to_pit  (data_fib_to_pit),
        .pit_data_valid   (pit_data_valid)
    );

    fib_lookup #(
        .ROUTES (ROUTES)
    ) u_fib_lookup (
        .clk             (clk),
        .rst_n           (rst_n),
        .route_we        (route_we),
        .route_index     (route_index),
        .route_prefix    (route_prefix),
        .route_mask      (route_mask),
        .fib_out_bit     (fib_out_bit),
        .pit_in_prefix   (pit_in_prefix),
        .pit_in_metadata (pit_in_metadata),
        .tx_done         (tx_done),
        .load            (load),
        .load_prefix     (load_prefix),
        .load_metadata   (load_metadata),
        .fib_miss        (fib_miss),
        .fib_busy        (fib_busy)
    );

    tx_serializer u_tx_serializer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .load                 (load),
        .load_prefix          (load_prefix),
        .load_metadata        (load_metadata),
        .data_fib_to_spi      (data_fib_to_spi),
        .fib_to_spi_data_flag (fib_to_spi_data_flag),
        .tx_done              (tx_done)
    );

endmodule

//--- sim/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset leaves on a falling edge, away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- sim/fib_checker.sv
module fib_checker #(
    parameter int PAYLOAD_BYTES = 32
) (
    input  logic        clk,
    input  logic        go,
    input  logic [3:0]  exp_kind,
    input  logic [7:0]  exp_meta,
    input  logic [63:0] exp_prefix,
    input  logic [7:0]  exp_arg,
    input  logic        exp_rej,
    input  logic        rx_valid,
    input  logic        prefix_ready,
    input  logic [63:0] pit_out_prefix,
    input  logic [7:0]  pit_out_metadata,
    input  logic        pit_data_valid,
    input  logic [7:0]  data_fib_to_pit,
    input  logic        fib_out_bit,
    input  logic        fib_miss,
    input  logic        fib_busy,
    input  logic        fib_to_spi_data_flag,
    input  logic [7:0]  data_fib_to_spi,
    output int          done_cnt,
    output int          pass_cnt,
    output int          fail_cnt
);

    int errs;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic complain(input string what);
        $display("error: %s", what);
        errs++;
    endtask

    function automatic string describe();
        if (exp_kind == 4'h1 && exp_meta[6]) return "interest frame";
        if (exp_kind == 4'h1) return exp_rej ? "data frame, rejected" : "data frame, accepted";
        if (exp_arg == 8'hff) return "lookup, miss";
        return $sformatf("lookup, hit through route %0d", exp_arg);
    endfunction

    task automatic check_frame();
        int n_rx;
        int last_hdr;
        int n_hdr;
        int n_pay;
        int exp_pay;
        n_rx     = 0;
        last_hdr = -2;
        n_hdr    = 0;
        n_pay    = 0;
        // Interests and rejected frames deliver no payload
        exp_pay  = (exp_meta[6] || exp_rej) ? 0 : PAYLOAD_BYTES;
        for (int cyc = 0; cyc < PAYLOAD_BYTES + 14; cyc++) begin
            @(posedge clk);
            if (prefix_ready) begin
                if (cyc != last_hdr + 1) begin
                    complain("prefix_ready not one cycle after the last header byte");
                end
                compare("pit_out_prefix", pit_out_prefix, exp_prefix);
                compare("pit_out_metadata", pit_out_metadata, exp_meta);
                n_hdr++;
            end
            if (pit_data_valid) begin
                if (n_pay < exp_pay) begin
                    compare("data_fib_to_pit", data_fib_to_pit, 8'(exp_arg + n_pay));
                end
                n_pay++;
            end
            if (rx_valid) begin
                n_rx++;
                if (n_rx == 9) last_hdr = cyc;
            end
        end
        if (n_hdr != 1) complain($sformatf("expected one prefix_ready, saw %0d", n_hdr));
        if (n_pay != exp_pay) begin
            complain($sformatf("expected %0d payload bytes, saw %0d", exp_pay, n_pay));
        end
    endtask

    task automatic check_lookup();
        int          t;
        int          n_bytes;
        int          n_miss;
        int          busy_span;
        logic [71:0] hdr;
        t         = -100;
        n_bytes   = 0;
        n_miss    = 0;
        hdr       = {exp_meta, exp_prefix};
        // Busy covers the lookup cycle and, on a hit, all nine SPI bytes
        busy_span = (exp_arg == 8'hff) ? 1 : 10;
        for (int cyc = 0; cyc < 16; cyc++) begin
            @(posedge clk);
            if (fib_out_bit) t = cyc;
            compare("fib_busy", fib_busy, (cyc > t) && (cyc <= t + busy_span));
            if (fib_miss) begin
                if (cyc != t + 1) complain("fib_miss not one cycle after the request");
                n_miss++;
            end
            if (fib_to_spi_data_flag) begin
                if (cyc != t + 2 + n_bytes) complain("SPI output late or not contiguous");
                if (n_bytes < 9) begin
                    compare("data_fib_to_spi", data_fib_to_spi, hdr[71 - 8*n_bytes -: 8]);
                end
                n_bytes++;
            end
        end
        if (exp_arg != 8'hff && (n_bytes != 9 || n_miss != 0)) begin
            complain($sformatf("expected a hit with 9 SPI bytes, saw %0d bytes, %0d misses",
                               n_bytes, n_miss));
        end else if (exp_arg == 8'hff && (n_bytes != 0 || n_miss != 1)) begin
            complain($sformatf("expected one miss and no SPI bytes, saw %0d bytes, %0d misses",
                               n_bytes, n_miss));
        end
    endtask

    initial begin
        done_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        forever begin
            do @(posedge clk); while (go !== 1'b1);
            errs = 0;
            case (exp_kind)
                4'h1: check_frame();
                4'h3: check_lookup();
                default: complain("record kind has no check");
            endcase
            if (errs == 0) pass_cnt++;
            else fail_cnt++;
            $display("test %0d %s: %s", done_cnt + 1, describe(), (errs == 0) ? "ok" : "bad");
            done_cnt++;
        end
    end

endmodule

//--- sim/fib_tb.sv
module fib_tb;

    localparam int PAYLOAD_BYTES = 32;
    localparam int ROUTES        = 8;
    localparam int MAX_REC       = 64;

    logic        clk;
    logic        rst_n;
    logic        rx_valid;
    logic [7:0]  data_spi_to_fib;
    logic        rejected;
    logic [63:0] pit_out_prefix;
    logic [7:0]  pit_out_metadata;
    logic        prefix_ready;
    logic [7:0]  data_fib_to_pit;
    logic        pit_data_valid;
    logic        route_we;
    logic [2:0]  route_index;
    logic [63:0] route_prefix;
    logic [63:0] route_mask;
    logic        fib_out_bit;
    logic [63:0] pit_in_prefix;
    logic [7:0]  pit_in_metadata;
    logic        fib_miss;
    logic        fib_busy;
    logic [7:0]  data_fib_to_spi;
    logic        fib_to_spi_data_flag;

    // Expected record for the checker
    logic        go;
    logic [3:0]  exp_kind;
    logic [7:0]  exp_meta;
    logic [63:0] exp_prefix;
    logic [7:0]  exp_arg;
    logic        exp_rej;
    int          done_cnt;
    int          pass_cnt;
    int          fail_cnt;

    logic [3:0]  rec_kind [MAX_REC];
    logic [7:0]  rec_f1   [MAX_REC];
    logic [63:0] rec_f2   [MAX_REC];
    logic [63:0] rec_f3   [MAX_REC];
    logic [7:0]  rec_f4   [MAX_REC];
    int          n_rec;
    int          n_checked;
    int          bad_rec;
    bit          loaded;
    bit          file_bad;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(5)) u_clock (.*);

    fib_top #(.ROUTES(ROUTES), .PAYLOAD_BYTES(PAYLOAD_BYTES)) UUT (.*);

    fib_checker #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_checker (.*);

    task automatic read_trace();
        int          fd;
        int          cnt;
        string       line;
        logic [63:0] k;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] d;
        n_rec = 0;
        fd = $fopen("sim/fib_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/fib_trace.txt");
            file_bad = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%h %h %h %h %h", k, a, b, c, d);
                if (cnt == 5 && n_rec < MAX_REC) begin
                    rec_kind[n_rec] = k[3:0];
                    rec_f1[n_rec]   = a[7:0];
                    rec_f2[n_rec]   = b;
                    rec_f3[n_rec]   = c;
                    rec_f4[n_rec]   = d[7:0];
                    n_rec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Called on a falling edge, returns one falling edge later
    task automatic hand_over(input int i);
        exp_kind   = rec_kind[i];
        exp_meta   = rec_f1[i];
        exp_prefix = rec_f2[i];
        exp_arg    = rec_f3[i][7:0];
        exp_rej    = rec_f4[i][0];
        go         = 1'b1;
        n_checked++;
        @(negedge clk);
        go = 1'b0;
    endtask

    task automatic wait_checker();
        while (done_cnt != n_checked) @(negedge clk);
    endtask

    task automatic send_frame(input int i);
        logic [71:0] hdr;
        hdr = {rec_f1[i], rec_f2[i]};
        hand_over(i);
        // Outside the prefix_ready cycle the verdict is inverted and must be ignored
        rejected = !rec_f4[i][0];
        for (int b = 0; b < 9; b++) begin
            rx_valid        = 1'b1;
            data_spi_to_fib = hdr[71 - 8*b -: 8];
            @(negedge clk);
        end
        // The PIT answers while prefix_ready is high
        rejected = rec_f4[i][0];
        if (!rec_f1[i][6]) begin
            for (int k = 0; k < PAYLOAD_BYTES; k++) begin
                data_spi_to_fib = 8'(rec_f3[i][7:0] + k);
                @(negedge clk);
                rejected = !rec_f4[i][0];
            end
        end
        rx_valid        = 1'b0;
        data_spi_to_fib = '0;
        wait_checker();
        rejected = 1'b0;
    endtask

    task automatic write_route(input int i);
        route_we     = 1'b1;
        route_index  = rec_f1[i][2:0];
        route_prefix = rec_f2[i];
        route_mask   = rec_f3[i];
        @(negedge clk);
        route_we = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_lookup(input int i);
        hand_over(i);
        fib_out_bit     = 1'b1;
        pit_in_prefix   = rec_f2[i];
        pit_in_metadata = rec_f1[i];
        @(negedge clk);
        fib_out_bit = 1'b0;
        wait_checker();
    endtask

    initial begin
        rx_valid        = 1'b0;
        data_spi_to_fib = '0;
        rejected        = 1'b0;
        route_we        = 1'b0;
        route_index     = '0;
        route_prefix    = '0;
        route_mask      = '0;
        fib_out_bit     = 1'b0;
        pit_in_prefix   = '0;
        pit_in_metadata = '0;
        go              = 1'b0;
        exp_kind        = '0;
        exp_meta        = '0;
        exp_prefix      = '0;
        exp_arg         = '0;
        exp_rej         = 1'b0;
        n_checked       = 0;
        bad_rec         = 0;
        file_bad        = 1'b0;
        read_trace();
        loaded = 1'b1;
        @(posedge rst_n);
        repeat (2) @(negedge clk);
        for (int i = 0; i < n_rec; i++) begin
            case (rec_kind[i])
                4'h1: send_frame(i);
                4'h2: write_route(i);
                4'h3: send_lookup(i);
                default: begin
                    $display("record %0d has unknown kind %0h", i, rec_kind[i]);
                    bad_rec++;
                end
            endcase
        end
        repeat (4) @(negedge clk);
        $display("tests run %0d, passed %0d, failed %0d", done_cnt, pass_cnt, fail_cnt);
        if (!file_bad && bad_rec == 0 && fail_cnt == 0 && n_checked > 0
            && pass_cnt == n_checked) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the number of records
    initial begin
        wait (loaded);
        repeat (n_rec * 60 + 200) @(posedge clk);
        $display("timeout after %0d cycles, run did not finish", n_rec * 60 + 200);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- sim/fib_trace.txt
# kind 1 frame:  metadata prefix payload_start_byte rejected
# kind 2 route:  index prefix mask 0
# kind 3 lookup: metadata prefix expected_route(ff = miss) 0
1 70 0123456789abcdef 00 0
1 30 a5a5000011112222 10 0
1 30 a5a5000011112222 80 1
1 70 fedcba9876543210 00 1
2 2 1234560000000000 ffffff0000000000 0
3 70 12345678deadbeef 2 0
2 0 cafe000000000000 ffff000000000000 0
2 1 caf0000000000000 fff0000000000000 0
3 70 cafe0123456789ab 0 0
2 0 beef000000000000 ffff000000000000 0
3 70 cafe0123456789ab 1 0
3 70 0000111122223333 ff 0
3 30 123456aa55aa55aa 2 0

//--- list.f
common/fib_pkg.sv
logic/rx_deframer.sv
logic/tx_serializer.sv
fib/fib_lookup.sv
fib/fib_top.sv
sim/tb_clock.sv
sim/fib_checker.sv
sim/fib_tb.sv

//--- Bender.yml
package:
  name: fib

sources:
  - files:
      - common/fib_pkg.sv
      - logic/rx_deframer.sv
      - logic/tx_serializer.sv
      - fib/fib_lookup.sv
      - fib/fib_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/fib_checker.sv
      - sim/fib_tb.sv
